//--- hdl/game_over_player.sv
`timescale 1ns/1ps

module game_over_player #(
    parameter int TONE_PERIOD = 100000
) (
    input  logic  clk,
    input  logic  rst_n,
    sfx_if.player fx
);

    localparam int CNT_W   = $clog2(TONE_PERIOD + 1);
    localparam int STAGE_W = $clog2(sound_pkg::GO_STAGES);

    sound_pkg::player_state_t state;
    logic [STAGE_W-1:0]       stage;
    logic [CNT_W-1:0]         cnt;
    logic [CNT_W-1:0]         high_time [16];
    logic                     period_end;
    logic                     last_stage;

    // High time per decay step, fixed at elaboration
    for (genvar i = 0; i < 16; i++) begin : g_duty
        assign high_time[i] = CNT_W'((TONE_PERIOD * int'(sound_pkg::DUTY_TABLE[i])) / 256);
    end

    assign period_end = (cnt == CNT_W'(TONE_PERIOD - 1));
    assign last_stage = (stage == STAGE_W'(sound_pkg::GO_STAGES - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= sound_pkg::IDLE;
            stage <= '0;
            cnt   <= '0;
        end else if (fx.abort) begin
            state <= sound_pkg::IDLE;
        end else if (fx.trigger) begin
            state <= sound_pkg::PLAY;   // Restart from stage 0 even when busy
            stage <= '0;
            cnt   <= '0;
        end else begin
            case (state)
                sound_pkg::PLAY: begin
                    if (period_end) begin
                        cnt <= '0;
                        if (last_stage) begin
                            state <= sound_pkg::DONE;
                        end else begin
                            stage <= stage + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                sound_pkg::DONE: state <= sound_pkg::IDLE;
                default:         state <= sound_pkg::IDLE;
            endcase
        end
    end

    assign fx.busy = (state == sound_pkg::PLAY);
    assign fx.done = (state == sound_pkg::DONE);

    // Second pass reuses the table through the low stage bits
    assign fx.wave = fx.busy && (cnt < high_time[stage[3:0]]);

    // A high pulse only ever opens a tone period
    a_high_at_period_start: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(fx.wave) |-> (cnt == '0)
    );

endmodule

//--- hdl/jump_player.sv
`timescale 1ns/1ps

module jump_player #(
    parameter int TONE_PERIOD = 100000
) (
    input  logic  clk,
    input  logic  rst_n,
    sfx_if.player fx
);

    localparam int HALF_MAX = (TONE_PERIOD * int'(sound_pkg::JUMP_HALF_TABLE[0])) / 256;
    localparam int HALF_W   = $clog2(HALF_MAX + 1);
    localparam int STEP_W   = $clog2(sound_pkg::JUMP_STEPS);
    localparam int HALVES_W = $clog2(sound_pkg::JUMP_HALVES_PER_STEP);

    sound_pkg::player_state_t state;
    logic [STEP_W-1:0]        step;
    logic [HALVES_W-1:0]      half_idx;  // Half-periods played in this step
    logic [HALF_W-1:0]        cnt;
    logic [HALF_W-1:0]        half_len [sound_pkg::JUMP_STEPS];
    logic                     half_end;
    logic                     step_end;
    logic                     last_step;

    for (genvar i = 0; i < sound_pkg::JUMP_STEPS; i++) begin : g_half
        assign half_len[i] = HALF_W'((TONE_PERIOD * int'(sound_pkg::JUMP_HALF_TABLE[i])) / 256);
    end

    assign half_end  = (cnt == half_len[step] - 1'b1);
    assign step_end  = (half_idx == HALVES_W'(sound_pkg::JUMP_HALVES_PER_STEP - 1));
    assign last_step = (step == STEP_W'(sound_pkg::JUMP_STEPS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= sound_pkg::IDLE;
            step     <= '0;
            half_idx <= '0;
            cnt      <= '0;
        end else if (fx.abort) begin
            state <= sound_pkg::IDLE;  // Game over wins, no done
        end else if (fx.trigger) begin
            state    <= sound_pkg::PLAY;
            step     <= '0;
            half_idx <= '0;
            cnt      <= '0;
        end else begin
            case (state)
                sound_pkg::PLAY: begin
                    if (half_end) begin
                        cnt      <= '0;
                        half_idx <= half_idx + 1'b1;  // Wraps into the next step
                        if (step_end) begin
                            if (last_step) begin
                                state <= sound_pkg::DONE;
                            end else begin
                                step <= step + 1'b1;
                            end
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                sound_pkg::DONE: state <= sound_pkg::IDLE;
                default:         state <= sound_pkg::IDLE;
            endcase
        end
    end

    assign fx.busy = (state == sound_pkg::PLAY);
    assign fx.done = (state == sound_pkg::DONE);
    assign fx.wave = fx.busy & ~half_idx[0];  // Even halves are high

    // A high half starts with a fresh half-period count
    a_high_at_half_start: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(fx.wave) |-> (cnt == '0)
    );

endmodule

//--- hdl/sfx_if.sv
`timescale 1ns/1ps

interface sfx_if (
    input logic clk
);

    logic trigger;  // One-cycle start pulse, restarts a running effect
    logic abort;    // Level, drops the player to idle without done
    logic busy;
    logic done;     // One-cycle pulse after a normal finish
    logic wave;

    modport host (
        output trigger,
        output abort,
        input  busy,
        input  done,
        input  wave
    );

    modport player (
        input  trigger,
        input  abort,
        output busy,
        output done,
        output wave
    );

    // Busy falls exactly in the done cycle
    a_done_ends_busy: assert property (@(posedge clk) done |-> $fell(busy));

endinterface

//--- hdl/sound_apb_regs.sv
`timescale 1ns/1ps

module sound_apb_regs (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        is_jump,
    input  logic        is_over,
    output logic        mute,
    sfx_if.host         go_if,
    sfx_if.host         jump_if
);

    logic                     access;
    logic                     wr_en;
    logic                     mapped;
    logic                     ro_addr;
    logic                     trig_wr;
    logic                     jump_pin_q;
    logic                     over_pin_q;
    logic                     jump_trig;
    logic                     go_trig;
    logic [7:0]               jump_cnt;
    logic [7:0]               over_cnt;
    sound_pkg::sound_status_t status;

    assign access  = psel & penable;   // No wait states, access cycle completes
    assign wr_en   = access & pwrite;
    assign mapped  = (paddr[1:0] == 2'b00);
    assign ro_addr = (paddr == sound_pkg::ADDR_STATUS) | (paddr == sound_pkg::ADDR_COUNT);
    assign trig_wr = wr_en & (paddr == sound_pkg::ADDR_TRIG);

    assign pready  = 1'b1;
    assign pslverr = access & (~mapped | (pwrite & ro_addr));

    assign status.jump_busy = jump_if.busy;
    assign status.over_busy = go_if.busy;

    always_comb begin
        prdata = '0;
        case (paddr)
            sound_pkg::ADDR_CTRL:   prdata[sound_pkg::CTRL_MUTE_BIT] = mute;
            sound_pkg::ADDR_STATUS: prdata[$bits(status)-1:0] = status;
            sound_pkg::ADDR_COUNT:  prdata[15:0] = {over_cnt, jump_cnt};
            default:                prdata = '0;  // TRIG and holes read zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mute <= 1'b0;
        end else if (wr_en && paddr == sound_pkg::ADDR_CTRL) begin
            mute <= pwdata[sound_pkg::CTRL_MUTE_BIT];
        end
    end

    // Pins are edge detected so a held pin starts the effect only once
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            jump_pin_q <= 1'b0;
            over_pin_q <= 1'b0;
            jump_trig  <= 1'b0;
            go_trig    <= 1'b0;
        end else begin
            jump_pin_q <= is_jump;
            over_pin_q <= is_over;
            jump_trig  <= (trig_wr & pwdata[sound_pkg::TRIG_JUMP_BIT]) | (is_jump & ~jump_pin_q);
            go_trig    <= (trig_wr & pwdata[sound_pkg::TRIG_OVER_BIT]) | (is_over & ~over_pin_q);
        end
    end

    assign jump_if.trigger = jump_trig;
    assign go_if.trigger   = go_trig;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            jump_cnt <= '0;
            over_cnt <= '0;
        end else begin
            if (jump_if.done) begin
                jump_cnt <= jump_cnt + 8'd1;  // Wraps at 256
            end
            if (go_if.done) begin
                over_cnt <= over_cnt + 8'd1;
            end
        end
    end

    // APB writes and pin edges must not land in adjacent cycles
    a_jump_trig_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) jump_trig |=> !jump_trig
    );
    a_go_trig_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) go_trig |=> !go_trig
    );

endmodule

//--- hdl/sound_mixer.sv
`timescale 1ns/1ps

module sound_mixer (
    input  logic clk,
    input  logic rst_n,
    input  logic mute,
    sfx_if.host  go_if,
    sfx_if.host  jump_if,
    output logic wave_out
);

    logic sel_wave;

    // Game over pre-empts a jump from the trigger cycle on
    assign jump_if.abort = go_if.busy | go_if.trigger;
    assign go_if.abort   = 1'b0;  // Nothing outranks game over

    assign sel_wave = go_if.busy ? go_if.wave : jump_if.wave;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wave_out <= 1'b0;
        end else begin
            wave_out <= sel_wave & ~mute;  // Registered pin, one cycle behind the players
        end
    end

    // Never two effects at once, game over wins
    a_one_effect: assert property (
        @(posedge clk) disable iff (!rst_n) go_if.busy |-> !jump_if.busy
    );

endmodule

//--- hdl/sound_pkg.sv
package sound_pkg;

    // APB register map, byte addresses on a 4-bit paddr
    localparam logic [3:0] ADDR_CTRL   = 4'h0;  // Bit 0 mute
    localparam logic [3:0] ADDR_TRIG   = 4'h4;  // Write-one start bits, reads zero
    localparam logic [3:0] ADDR_STATUS = 4'h8;  // Busy flags, read-only
    localparam logic [3:0] ADDR_COUNT  = 4'hC;  // Completion counters, read-only

    localparam int CTRL_MUTE_BIT = 0;
    localparam int TRIG_JUMP_BIT = 0;
    localparam int TRIG_OVER_BIT = 1;

    // Game-over duty decay in 1/256 of the tone period
    localparam logic [7:0] DUTY_TABLE [16] = '{
        8'd48, 8'd43, 8'd38, 8'd34, 8'd30, 8'd27, 8'd24, 8'd21,
        8'd19, 8'd17, 8'd15, 8'd13, 8'd12, 8'd11, 8'd10, 8'd9
    };

    // Jump half-periods in 1/256 of the tone period, shrinking so pitch rises
    localparam logic [7:0] JUMP_HALF_TABLE [8] = '{
        8'd64, 8'd56, 8'd48, 8'd40, 8'd32, 8'd28, 8'd24, 8'd20
    };

    localparam int GO_STAGES            = 32;  // Decay table played twice
    localparam int JUMP_STEPS           = 8;
    localparam int JUMP_HALVES_PER_STEP = 16;

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        PLAY = 2'b01,
        DONE = 2'b10  // One cycle, carries the done pulse
    } player_state_t;

    // STATUS register layout, bit 0 is jump busy
    typedef struct packed {
        logic over_busy;
        logic jump_busy;
    } sound_status_t;

endpackage

//--- hdl/sound_top.sv
`timescale 1ns/1ps

module sound_top #(
    parameter int TONE_PERIOD = 100000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        is_jump,
    input  logic        is_over,
    output logic        wave_out
);

    logic mute;

    sfx_if go_if (.clk(clk));    // Game-over player link
    sfx_if jump_if (.clk(clk));  // Jump player link

    sound_apb_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .is_jump (is_jump),
        .is_over (is_over),
        .mute    (mute),
        .go_if   (go_if.host),
        .jump_if (jump_if.host)
    );

    game_over_player #(
        .TONE_PERIOD (TONE_PERIOD)
    ) u_game_over (
        .clk   (clk),
        .rst_n (rst_n),
        .fx    (go_if.player)
    );

    jump_player #(
        .TONE_PERIOD (TONE_PERIOD)
    ) u_jump (
        .clk   (clk),
        .rst_n (rst_n),
        .fx    (jump_if.player)
    );

    sound_mixer u_mixer (
        .clk      (clk),
        .rst_n    (rst_n),
        .mute     (mute),
        .go_if    (go_if.host),
        .jump_if  (jump_if.host),
        .wave_out (wave_out)
    );

endmodule

//--- project.f
+incdir+tb
hdl/sound_pkg.sv
hdl/sfx_if.sv
hdl/sound_apb_regs.sv
hdl/game_over_player.sv
hdl/jump_player.sv
hdl/sound_mixer.sv
hdl/sound_top.sv
tb/tb_sound_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_sound_top -o tb_sound_top

output=$(./obj_dir/tb_sound_top)
echo "$output"

if grep -q "^NO ERRORS$" <<< "$output"; then
    exit 0
fi
exit 1

//--- tb/tb_sound_tasks.svh
// One APB transfer, setup then access, sampled mid access cycle
task automatic apb_transfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    check_ready("access cycle", pready);
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused_rd;
    apb_transfer(1'b1, addr, data, unused_rd, err);
endtask

task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
    apb_transfer(1'b0, addr, 32'h0, data, err);
endtask

task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks_run++;
    if (got !== exp) begin
        err_count++;
        $display("ERR %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
endtask

task automatic check_status(input string what, input sound_pkg::sound_status_t got,
                            input sound_pkg::sound_status_t exp);
    checks_run++;
    if (got !== exp) begin
        err_count++;
        $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic check_count(input string what, input int got, input int exp);
    checks_run++;
    if (got != exp) begin
        err_count++;
        $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_err(input string what, input logic got, input logic exp);
    checks_run++;
    if (got !== exp) begin
        err_count++;
        $display("ERR %0t: %s pslverr %b, expected %b", $time, what, got, exp);
    end
endtask

// No wait states, so pready is high in every access cycle
task automatic check_ready(input string what, input logic got);
    checks_run++;
    if (got !== 1'b1) begin
        err_count++;
        $display("ERR %0t: %s pready %b, expected 1", $time, what, got);
    end
endtask

task automatic pulse_pin(input logic jump, input logic over);
    @(posedge clk);
    #2;
    is_jump = jump;
    is_over = over;
    @(posedge clk);
    #2;
    is_jump = 1'b0;
    is_over = 1'b0;
endtask

task automatic wait_wave_high(output int cycles);
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
    end while (!wave_out && cycles < 20);
    if (!wave_out) begin
        err_count++;
        $display("wave_out never went high after the trigger");
    end
endtask

task automatic wait_idle();
    logic [31:0] rd;
    logic        err;
    int          tries;
    tries = 0;
    do begin
        apb_read(sound_pkg::ADDR_STATUS, rd, err);
        tries++;
    end while (rd[1:0] != 2'b00 && tries < 1000);
    if (rd[1:0] != 2'b00) begin
        err_count++;
        $display("An effect was still busy after %0d status polls", tries);
    end
endtask

// Current negedge is the first cycle of stage 0
task automatic measure_high_per_stage();
    int s;
    int c;
    for (s = 0; s < sound_pkg::GO_STAGES; s++) begin
        stage_high[s] = 0;
        for (c = 0; c < TONE_PERIOD; c++) begin
            if (s != 0 || c != 0) begin
                @(negedge clk);
            end
            if (wave_out) begin
                stage_high[s]++;
            end
        end
    end
endtask

task automatic check_stage_highs(input string what);
    int s;
    for (s = 0; s < sound_pkg::GO_STAGES; s++) begin
        check_count($sformatf("%s stage %0d high time", what, s), stage_high[s],
                    TONE_PERIOD * int'(sound_pkg::DUTY_TABLE[s % 16]) / 256);
    end
endtask

task automatic count_rising_edges(input int window, output int edges, output int highs);
    logic prev;
    int   i;
    edges = 0;
    highs = 0;
    prev  = wave_out;
    for (i = 0; i < window; i++) begin
        @(negedge clk);
        if (wave_out && !prev) begin
            edges++;
        end
        if (wave_out) begin
            highs++;
        end
        prev = wave_out;
    end
endtask

task automatic count_jump_busy(input int window, output int len);
    int i;
    len = 0;
    for (i = 0; i < window; i++) begin
        @(negedge clk);
        if (u_dut.jump_if.busy) begin
            len++;
        end
    end
endtask

task automatic read_status_later(input string what, input sound_pkg::sound_status_t exp);
    logic [31:0] rd;
    logic        err;
    repeat (300) @(posedge clk);  // Well inside the effect
    apb_read(sound_pkg::ADDR_STATUS, rd, err);
    check_status(what, sound_pkg::sound_status_t'(rd[1:0]), exp);
endtask

task automatic test_registers();
    logic [31:0] rd;
    logic [31:0] rnd;
    logic [3:0]  addr;
    logic        err;
    int          i;
    apb_read(sound_pkg::ADDR_CTRL, rd, err);
    check_word("CTRL after reset", rd, 32'h0);
    apb_read(sound_pkg::ADDR_STATUS, rd, err);
    check_status("STATUS after reset", sound_pkg::sound_status_t'(rd[1:0]), 2'b00);
    apb_read(sound_pkg::ADDR_COUNT, rd, err);
    check_word("COUNT after reset", rd, 32'h0);
    check_err("COUNT read", err, 1'b0);
    rnd = $random(seed);
    apb_write(sound_pkg::ADDR_CTRL, {rnd[31:1], 1'b1}, err);
    apb_read(sound_pkg::ADDR_CTRL, rd, err);
    check_word("CTRL mute readback", rd, 32'h1);
    apb_write(sound_pkg::ADDR_CTRL, {rnd[31:1], 1'b0}, err);
    apb_write(sound_pkg::ADDR_STATUS, rnd, err);
    check_err("STATUS write", err, 1'b1);
    apb_write(sound_pkg::ADDR_COUNT, rnd, err);
    check_err("COUNT write", err, 1'b1);
    for (i = 0; i < 6; i++) begin
        rnd  = $random(seed);
        addr = {rnd[3:2], (rnd[1:0] == 2'b00) ? 2'b11 : rnd[1:0]};  // Never word aligned
        if (rnd[4]) begin
            apb_write(addr, rnd, err);
        end else begin
            apb_read(addr, rd, err);
        end
        check_err($sformatf("unmapped access at 0x%h", addr), err, 1'b1);
    end
endtask

task automatic test_game_over_apb();
    logic [31:0] rd;
    logic        err;
    int          lat;
    apb_write(sound_pkg::ADDR_TRIG, 32'h2, err);
    wait_wave_high(lat);
    check_count("TRIG to wave_out latency", lat, 3);
    fork
        measure_high_per_stage();
        read_status_later("STATUS during game over", 2'b10);
    join
    check_stage_highs("APB game over");
    wait_idle();
    apb_read(sound_pkg::ADDR_COUNT, rd, err);
    check_word("COUNT after game over", rd, 32'h0000_0100);
endtask

task automatic test_jump_pin();
    logic [31:0] rd;
    logic        err;
    int          edges;
    int          highs;
    int          busy_len;
    int          exp_len;
    int          k;
    exp_len = 0;
    for (k = 0; k < sound_pkg::JUMP_STEPS; k++) begin
        exp_len += sound_pkg::JUMP_HALVES_PER_STEP *
                   (TONE_PERIOD * int'(sound_pkg::JUMP_HALF_TABLE[k]) / 256);
    end
    pulse_pin(1'b1, 1'b0);
    fork
        count_rising_edges(1300, edges, highs);
        count_jump_busy(1300, busy_len);
    join
    check_count("jump rising edges", edges,
                sound_pkg::JUMP_STEPS * sound_pkg::JUMP_HALVES_PER_STEP / 2);
    check_count("jump busy cycles", busy_len, exp_len);
    check_count("jump high cycles", highs, exp_len / 2);  // Every other half is high
    wait_idle();
    apb_read(sound_pkg::ADDR_COUNT, rd, err);
    check_word("COUNT after jump", rd, 32'h0000_0101);
endtask

task automatic test_priority_abort();
    logic [31:0] rd;
    logic        err;
    pulse_pin(1'b1, 1'b0);
    repeat (200) @(posedge clk);  // Jump is mid sweep
    pulse_pin(1'b0, 1'b1);
    repeat (3) @(negedge clk);
    measure_high_per_stage();
    check_stage_highs("game over after abort");
    wait_idle();
    apb_read(sound_pkg::ADDR_COUNT, rd, err);
    check_word("COUNT after abort", rd, 32'h0000_0201);  // Jump count unchanged
endtask

task automatic test_mute();
    logic [31:0] rd;
    logic        err;
    int          edges;
    int          highs;
    apb_write(sound_pkg::ADDR_CTRL, 32'h1, err);
    apb_write(sound_pkg::ADDR_TRIG, 32'h2, err);
    fork
        count_rising_edges(sound_pkg::GO_STAGES * TONE_PERIOD + 8, edges, highs);
        read_status_later("STATUS during muted game over", 2'b10);
    join
    check_count("muted rising edges", edges, 0);
    check_count("muted high cycles", highs, 0);
    wait_idle();
    apb_read(sound_pkg::ADDR_COUNT, rd, err);
    check_word("COUNT after muted game over", rd, 32'h0000_0301);
    apb_write(sound_pkg::ADDR_CTRL, 32'h0, err);
endtask

//--- tb/tb_sound_top.sv
`timescale 1ns/1ps

module tb_sound_top;

    localparam int TONE_PERIOD = 64;
    // Three game overs of 2048 cycles, a 1300 cycle jump window, APB polls and margin
    localparam int MAX_CYCLES  = 12000;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        is_jump;
    logic        is_over;
    logic        wave_out;

    int err_count   = 0;
    int checks_run  = 0;
    int cycle_count = 0;
    int seed;
    int stage_high [sound_pkg::GO_STAGES];  // High cycles seen per game-over stage

    sound_top #(
        .TONE_PERIOD (TONE_PERIOD)
    ) u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .is_jump  (is_jump),
        .is_over  (is_over),
        .wave_out (wave_out)
    );

    `include "tb_sound_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
        end
        $display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        seed    = 70790;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        is_jump = 1'b0;
        is_over = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_registers();
        test_game_over_apb();
        test_jump_pin();
        test_priority_abort();
        test_mute();

        $display("Checks run: %0d, errors: %0d", checks_run, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
